/* design/life_pkg.sv */
/* Grid is sized for simulation, 16x16 with a 16-bit seed LFSR.
   All intervals are counted in clk4 cycles and must be rescaled for hardware. */
`default_nettype none

package life_pkg;

	////////////////////////////////////////////////////////////
	// Grid geometry
	////////////////////////////////////////////////////////////

	localparam int LIFE_WIDTH = 16; // Cells per row, one memory word
	localparam int LIFE_ROWS  = 16; // Rows in one bank
	localparam int ROW_BITS   = 4;  // Row address width

	// One grid row, bit 0 is the leftmost cell, 1 = alive
	typedef logic [LIFE_WIDTH-1:0] row_t;

	////////////////////////////////////////////////////////////
	// Seed LFSR
	////////////////////////////////////////////////////////////

	// Fibonacci, shifts right, new msb is xor of tapped bits
	localparam logic [15:0] LFSR_SEED = 16'hACE1; // Must be nonzero
	localparam logic [15:0] LFSR_TAPS = 16'hB400; // Bits 15 13 12 10

	////////////////////////////////////////////////////////////
	// Button timing
	////////////////////////////////////////////////////////////

	localparam int TICK_CYCLES   = 4;  // clk4 cycles per debounce tick
	localparam int PRESS_TICKS   = 5;  // Stable high before a press counts
	localparam int LONG_TICKS    = 40; // Continuous hold before run mode
	localparam int RELEASE_TICKS = 10; // Stable low before next press

	////////////////////////////////////////////////////////////
	// Statistics
	////////////////////////////////////////////////////////////

	localparam int SECOND_CYCLES  = 2000; // One rate window
	localparam int GEN_COUNT_BITS = 32;   // Total generation counter
	localparam int RATE_BITS      = 16;   // Generations per window

endpackage

`default_nettype wire

/* design/button_debounce.sv */
/* Button must be clean at tick resolution; glitches shorter than a press
   are dropped. long_go stays up through the release filter time. */
`timescale 1ns/1ns
`default_nettype none

module button_debounce (
	input  wire logic clk4,
	input  wire logic reset,
	input  wire logic button,
	output logic      short_go, // One cycle per accepted press
	output logic      long_go   // Level while held past LONG_TICKS
);

	typedef enum logic [2:0] {
		s_idle,
		s_wait_press,
		s_pulse,
		s_wait_long,
		s_long,
		s_wait_off,
		s_wait_loff
	} state_t;

	state_t state;
	logic [2:0] sync;   // Metastability chain
	logic       btn;    // Synchronized button
	logic [$clog2(life_pkg::TICK_CYCLES)-1:0] pre_cnt;
	logic       tick;
	logic [$clog2(life_pkg::LONG_TICKS+1)-1:0]    hold_cnt; // Ticks held high
	logic [$clog2(life_pkg::RELEASE_TICKS+1)-1:0] low_cnt;  // Ticks seen low

	always_ff @(posedge clk4) begin
		sync <= {sync[1:0], button};
	end
	assign btn = sync[2];

	// Tick prescaler, free running from reset
	always_ff @(posedge clk4) begin
		if (reset) begin
			pre_cnt <= '0;
		end else begin
			pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
		end
	end
	assign tick = (pre_cnt == life_pkg::TICK_CYCLES - 1);

	////////////////////////////////////////////////////////////
	// Press state machine
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk4) begin
		if (reset) begin
			state <= s_idle;
		end else begin
			case (state)
				s_idle:       state <= btn ? s_wait_press : s_idle;
				s_wait_press: begin
					if (!btn)
						state <= s_idle; // Too short, no output
					else if (tick && hold_cnt == life_pkg::PRESS_TICKS - 1)
						state <= s_pulse;
				end
				s_pulse:      state <= s_wait_long; // Single cycle
				s_wait_long: begin
					if (!btn)
						state <= s_wait_off;
					else if (tick && hold_cnt == life_pkg::LONG_TICKS - 1)
						state <= s_long;
				end
				s_long:       state <= btn ? s_long : s_wait_loff;
				s_wait_off: begin
					if (btn)
						state <= s_wait_long; // Bounce, keep hold count
					else if (tick && low_cnt == life_pkg::RELEASE_TICKS - 1)
						state <= s_idle;
				end
				s_wait_loff: begin
					if (btn)
						state <= s_long;
					else if (tick && low_cnt == life_pkg::RELEASE_TICKS - 1)
						state <= s_idle;
				end
				default:      state <= s_idle;
			endcase
		end
	end

	// Tick counters for hold and release
	always_ff @(posedge clk4) begin
		if (reset) begin
			hold_cnt <= '0;
			low_cnt  <= '0;
		end else begin
			if (state == s_idle)
				hold_cnt <= '0;
			else if (tick && (state == s_wait_press || state == s_pulse ||
					state == s_wait_long))
				hold_cnt <= hold_cnt + 1'b1;
			if (state != s_wait_off && state != s_wait_loff)
				low_cnt <= '0; // Restart on any high
			else if (tick)
				low_cnt <= low_cnt + 1'b1;
		end
	end

	assign short_go = (state == s_pulse);
	assign long_go  = (state == s_long) || (state == s_wait_loff);

	// A press is accepted only after the full stable-high time
	a_press_time: assert property (@(posedge clk4) disable iff (reset)
		short_go |-> hold_cnt == life_pkg::PRESS_TICKS);

endmodule

`default_nettype wire

/* design/life_seed.sv */
/* Fills bank 0 once after reset, one row per cycle, then idles.
   Row r holds the LFSR state after r+1 steps. */
`timescale 1ns/1ns
`default_nettype none

module life_seed (
	input  wire logic                         clk4,
	input  wire logic                         reset,
	output logic                              seed_we,
	output logic [life_pkg::ROW_BITS-1:0]     seed_addr,
	output life_pkg::row_t                    seed_row,
	output logic                              seed_done
);

	logic [15:0] lfsr;
	logic [15:0] lfsr_next;
	logic [life_pkg::ROW_BITS-1:0] row_cnt;

	// One right shift, feedback into msb
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {^(s & life_pkg::LFSR_TAPS), s[15:1]};
	endfunction

	assign lfsr_next = lfsr_step(lfsr);

	always_ff @(posedge clk4) begin
		if (reset) begin
			lfsr      <= life_pkg::LFSR_SEED;
			row_cnt   <= '0;
			seed_done <= 1'b0;
		end else if (!seed_done) begin
			lfsr    <= lfsr_next; // Advance with every row written
			row_cnt <= row_cnt + 1'b1;
			if (row_cnt == life_pkg::LIFE_ROWS - 1)
				seed_done <= 1'b1; // Last row this cycle
		end
	end

	// Write port to the grid memory
	assign seed_we   = !seed_done;
	assign seed_addr = row_cnt;
	assign seed_row  = life_pkg::row_t'(lfsr_next); // Stepped state is the row

endmodule

`default_nettype wire

/* design/life_grid_ram.sv */
/* Two banks of LIFE_ROWS rows, read data one cycle after address.
   Read and write of the same row in one cycle returns the old row. */
`timescale 1ns/1ns
`default_nettype none

module life_grid_ram (
	input  wire logic                          clk4,
	input  wire logic                          bank,    // Read bank
	input  wire logic [life_pkg::ROW_BITS-1:0] rd_addr,
	output life_pkg::row_t                     rd_data,
	input  wire logic                          wr_en,
	input  wire logic                          wr_bank,
	input  wire logic [life_pkg::ROW_BITS-1:0] wr_addr,
	input  wire life_pkg::row_t                wr_row
);

	life_pkg::row_t mem [2][life_pkg::LIFE_ROWS]; // Ping-pong grid

	always_ff @(posedge clk4) begin
		if (wr_en)
			mem[wr_bank][wr_addr] <= wr_row;
		rd_data <= mem[bank][rd_addr]; // Registered read
	end

endmodule

`default_nettype wire

/* design/life_sequencer.sv */
/* A pass takes LIFE_ROWS+3 busy cycles plus the idle cycle that issues
   the first read. Readouts wait for the pass end; a newer request wins. */
`timescale 1ns/1ns
`default_nettype none

module life_sequencer (
	input  wire logic                          clk4,
	input  wire logic                          reset,
	input  wire logic                          seed_done,
	input  wire logic                          short_go,
	input  wire logic                          long_go,
	input  wire logic                          rd_req,
	input  wire logic [life_pkg::ROW_BITS-1:0] rd_row,
	input  wire life_pkg::row_t                mem_rd_data,
	output logic [life_pkg::ROW_BITS-1:0]      mem_rd_addr,
	output logic                               mem_wr_en,
	output logic                               mem_wr_bank,
	output logic [life_pkg::ROW_BITS-1:0]      mem_wr_addr,
	output life_pkg::row_t                     mem_wr_row,
	output logic                               bank,     // Current generation
	output logic                               busy,
	output logic                               gen_tick,
	output logic                               rd_valid,
	output life_pkg::row_t                     rd_data
);

	logic [$clog2(life_pkg::LIFE_ROWS+4)-1:0] step; // Busy cycle 1..LIFE_ROWS+3
	logic start;
	logic serve;
	logic pend;                                  // Readout waiting
	logic [life_pkg::ROW_BITS-1:0] pend_row;
	life_pkg::row_t win_up;                      // Row above
	life_pkg::row_t win_mid;                     // Row being computed
	life_pkg::row_t next_row;

	// B3/S23 over one row, columns wrap
	function automatic life_pkg::row_t life_step(input life_pkg::row_t up,
			input life_pkg::row_t mid, input life_pkg::row_t dn);
		int cl;
		int cr;
		logic [3:0] n;
		life_pkg::row_t res;
		for (int c = 0; c < life_pkg::LIFE_WIDTH; c++) begin
			cl = (c + life_pkg::LIFE_WIDTH - 1) % life_pkg::LIFE_WIDTH;
			cr = (c + 1) % life_pkg::LIFE_WIDTH;
			n = 4'(up[cl]) + 4'(up[c]) + 4'(up[cr]) +
				4'(mid[cl]) + 4'(mid[cr]) +
				4'(dn[cl]) + 4'(dn[c]) + 4'(dn[cr]);
			res[c] = (n == 4'd3) || (mid[c] && n == 4'd2); // Birth or survive
		end
		return res;
	endfunction

	////////////////////////////////////////////////////////////
	// Pass control
	////////////////////////////////////////////////////////////

	assign start = seed_done && !busy && !pend && (short_go || long_go);
	assign serve = !busy && pend; // Readout slot between passes

	// Read address, pass rows wrap 15,0..15,0
	always_comb begin
		if (busy)
			mem_rd_addr = life_pkg::ROW_BITS'(step - 1'b1);
		else if (start)
			mem_rd_addr = life_pkg::ROW_BITS'(life_pkg::LIFE_ROWS - 1); // Top wrap row
		else
			mem_rd_addr = pend_row;
	end

	always_ff @(posedge clk4) begin
		if (reset) begin
			busy      <= 1'b0;
			step      <= '0;
			bank      <= 1'b0;
			gen_tick  <= 1'b0;
			pend      <= 1'b0;
			rd_valid  <= 1'b0;
			mem_wr_en <= 1'b0;
		end else begin
			gen_tick  <= 1'b0;
			rd_valid  <= serve; // Data lands next cycle
			mem_wr_en <= busy && step >= 3 && step <= life_pkg::LIFE_ROWS + 2;
			if (start) begin
				busy <= 1'b1;
				step <= 1;
			end else if (busy) begin
				step <= step + 1'b1;
				if (step == life_pkg::LIFE_ROWS + 3) begin // Last write in flight
					busy     <= 1'b0;
					gen_tick <= 1'b1;
					bank     <= !bank; // New generation becomes current
				end
			end
			if (rd_req)
				pend <= 1'b1; // Replaces any older request
			else if (serve)
				pend <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Row window and write-back
	////////////////////////////////////////////////////////////

	assign next_row = life_step(win_up, win_mid, mem_rd_data); // Below comes from RAM

	always_ff @(posedge clk4) begin
		if (busy) begin
			win_up  <= win_mid;
			win_mid <= mem_rd_data;
		end
		mem_wr_row  <= next_row;
		mem_wr_addr <= life_pkg::ROW_BITS'(step - 2'd3); // Row r at step r+3
		mem_wr_bank <= !bank;                            // Always the other bank
		if (rd_req)
			pend_row <= rd_row;
	end

	assign rd_data = mem_rd_data;

	// Seed pass owns the memory until it finishes
	a_no_write_before_seed: assert property (@(posedge clk4) disable iff (reset)
		mem_wr_en |-> seed_done);

endmodule

`default_nettype wire

/* design/gen_stats.sv */
/* Windows are SECOND_CYCLES long and aligned to reset release.
   Counters wrap silently at their widths. */
`timescale 1ns/1ns
`default_nettype none

module gen_stats (
	input  wire logic                         clk4,
	input  wire logic                         reset,
	input  wire logic                         gen_tick,
	output logic [life_pkg::GEN_COUNT_BITS-1:0] gen_count,
	output logic [life_pkg::RATE_BITS-1:0]      gens_per_sec
);

	logic [$clog2(life_pkg::SECOND_CYCLES)-1:0] win_cnt; // Position in window
	logic [life_pkg::RATE_BITS-1:0] in_win;               // Ticks so far
	logic win_last;

	assign win_last = (win_cnt == life_pkg::SECOND_CYCLES - 1);

	// Total since reset
	always_ff @(posedge clk4) begin
		if (reset) begin
			gen_count <= '0;
		end else if (gen_tick) begin
			gen_count <= gen_count + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Rate window
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk4) begin
		if (reset) begin
			win_cnt      <= '0;
			in_win       <= '0;
			gens_per_sec <= '0;
		end else begin
			win_cnt <= win_last ? '0 : win_cnt + 1'b1;
			if (win_last) begin
				gens_per_sec <= in_win + gen_tick; // Tick on last cycle still counts
				in_win       <= '0;
			end else begin
				in_win <= in_win + gen_tick;
			end
		end
	end

endmodule

`default_nettype wire

/* design/life_top.sv */
/* Single clock, synchronous reset. rd_valid may come late when a
   readout collides with a running pass. */
`timescale 1ns/1ns
`default_nettype none

module life_top (
	input  wire logic                           clk4,
	input  wire logic                           reset,
	input  wire logic                           fire_button,
	input  wire logic                           rd_req,
	input  wire logic [life_pkg::ROW_BITS-1:0]  rd_row,
	output life_pkg::row_t                      rd_data,
	output logic                                rd_valid,
	output logic                                busy,
	output logic                                seed_done,
	output logic [life_pkg::GEN_COUNT_BITS-1:0] gen_count,
	output logic [life_pkg::RATE_BITS-1:0]      gens_per_sec
);

	logic short_go;
	logic long_go;
	logic gen_tick;
	logic bank;

	// Seed write port
	logic                          seed_we;
	logic [life_pkg::ROW_BITS-1:0] seed_addr;
	life_pkg::row_t                seed_row;

	// Sequencer memory port
	logic [life_pkg::ROW_BITS-1:0] mem_rd_addr;
	life_pkg::row_t                mem_rd_data;
	logic                          seq_wr_en;
	logic                          seq_wr_bank;
	logic [life_pkg::ROW_BITS-1:0] seq_wr_addr;
	life_pkg::row_t                seq_wr_row;

	// Muxed write port
	logic                          wr_en;
	logic                          wr_bank;
	logic [life_pkg::ROW_BITS-1:0] wr_addr;
	life_pkg::row_t                wr_row;

	button_debounce button_debounce_inst (
		.clk4     (clk4),
		.reset    (reset),
		.button   (fire_button),
		.short_go (short_go),
		.long_go  (long_go)
	);

	life_seed life_seed_inst (
		.clk4      (clk4),
		.reset     (reset),
		.seed_we   (seed_we),
		.seed_addr (seed_addr),
		.seed_row  (seed_row),
		.seed_done (seed_done)
	);

	// Seeding owns the write port until done, always into bank 0
	assign wr_en   = seed_done ? seq_wr_en   : seed_we;
	assign wr_bank = seed_done ? seq_wr_bank : 1'b0;
	assign wr_addr = seed_done ? seq_wr_addr : seed_addr;
	assign wr_row  = seed_done ? seq_wr_row  : seed_row;

	life_grid_ram life_grid_ram_inst (
		.clk4    (clk4),
		.bank    (bank),
		.rd_addr (mem_rd_addr),
		.rd_data (mem_rd_data),
		.wr_en   (wr_en),
		.wr_bank (wr_bank),
		.wr_addr (wr_addr),
		.wr_row  (wr_row)
	);

	life_sequencer life_sequencer_inst (
		.clk4        (clk4),
		.reset       (reset),
		.seed_done   (seed_done),
		.short_go    (short_go),
		.long_go     (long_go),
		.rd_req      (rd_req),
		.rd_row      (rd_row),
		.mem_rd_data (mem_rd_data),
		.mem_rd_addr (mem_rd_addr),
		.mem_wr_en   (seq_wr_en),
		.mem_wr_bank (seq_wr_bank),
		.mem_wr_addr (seq_wr_addr),
		.mem_wr_row  (seq_wr_row),
		.bank        (bank),
		.busy        (busy),
		.gen_tick    (gen_tick),
		.rd_valid    (rd_valid),
		.rd_data     (rd_data)
	);

	gen_stats gen_stats_inst (
		.clk4         (clk4),
		.reset        (reset),
		.gen_tick     (gen_tick),
		.gen_count    (gen_count),
		.gens_per_sec (gens_per_sec)
	);

endmodule

`default_nettype wire

/* sim/life_ref.svh */
/* Reference model of the grid, included inside the testbench module.
   Bit 0 of a row is the leftmost cell, rows and columns wrap around. */
`ifndef LIFE_REF_SVH
`define LIFE_REF_SVH

// Whole grid, index [row][column]
typedef logic [life_pkg::LIFE_ROWS-1:0][life_pkg::LIFE_WIDTH-1:0] grid_t;

// Seed LFSR, taps 15 13 12 10, shifts right
function automatic logic [15:0] seed_lfsr_next(input logic [15:0] s);
	logic fb;
	fb = s[15] ^ s[13] ^ s[12] ^ s[10]; // New msb
	return {fb, s[15:1]};
endfunction

// Row r is the state after r+1 steps
function automatic grid_t seed_grid();
	grid_t g;
	logic [15:0] s;
	s = life_pkg::LFSR_SEED;
	for (int r = 0; r < life_pkg::LIFE_ROWS; r++) begin
		s = seed_lfsr_next(s);
		g[r] = s;
	end
	return g;
endfunction

// One B3/S23 generation on a torus
function automatic grid_t life_generation(input grid_t g);
	grid_t nx;
	int n;
	int rr;
	int cc;
	for (int r = 0; r < life_pkg::LIFE_ROWS; r++) begin
		for (int c = 0; c < life_pkg::LIFE_WIDTH; c++) begin
			n = 0;
			for (int dr = -1; dr <= 1; dr++) begin
				for (int dc = -1; dc <= 1; dc++) begin
					rr = (r + dr + life_pkg::LIFE_ROWS) % life_pkg::LIFE_ROWS;
					cc = (c + dc + life_pkg::LIFE_WIDTH) % life_pkg::LIFE_WIDTH;
					if ((dr != 0 || dc != 0) && g[rr][cc])
						n++; // Live neighbor
				end
			end
			nx[r][c] = (n == 3) || (g[r][c] && n == 2); // Birth or survive
		end
	end
	return nx;
endfunction

// Stimulus LFSR, x^16+x^14+x^13+x^11+1 in right-shift form
function automatic logic [15:0] stim_lfsr_next(input logic [15:0] s);
	return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
endfunction

`endif

/* sim/tb_life_top.sv */
/* Inputs change on the falling clock edge and outputs are sampled there.
   Rate windows are counted in rising edges since reset release. */
`timescale 1ns/1ns
`default_nettype none

module tb_life_top;

	localparam int PERIOD       = 100;
	localparam int RESET_CYCLES = 10;
	localparam int SEED_WAIT    = 4 * life_pkg::LIFE_ROWS;
	localparam int READ_TIMEOUT = 4 * life_pkg::LIFE_ROWS + 16; // Longer than one pass
	localparam int SHORT_MAX    = 40 + 63;
	localparam int RELEASE_WAIT = 120; // Debounce back to idle
	localparam int GLITCHES     = 12;
	localparam int GLITCH_MAX   = 2 + 7;
	localparam int GLITCH_GAP   = 24;
	localparam int HOLD_MAX     = 300 + 127;
	localparam int MARGIN       = 1000;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + SEED_WAIT +
		5 * life_pkg::LIFE_ROWS * READ_TIMEOUT + 3 * (SHORT_MAX + RELEASE_WAIT) +
		GLITCHES * (GLITCH_MAX + GLITCH_GAP) + HOLD_MAX + RELEASE_WAIT +
		3 * life_pkg::SECOND_CYCLES + MARGIN;

	logic clk4;
	logic reset;
	logic fire_button;
	logic rd_req;
	logic [life_pkg::ROW_BITS-1:0]       rd_row;
	life_pkg::row_t                      rd_data;
	logic                                rd_valid;
	logic                                busy;
	logic                                seed_done;
	logic [life_pkg::GEN_COUNT_BITS-1:0] gen_count;
	logic [life_pkg::RATE_BITS-1:0]      gens_per_sec;

	`include "life_ref.svh"

	grid_t       model;            // Expected current generation
	logic [15:0] stim_lfsr;
	int          error_count = 0;
	int          check_count = 0;
	int          fall_count  = 0;  // Busy falls seen
	int          win_falls   = 0;  // Falls in the open window
	int          edge_cnt    = 0;  // Rising edges since reset release
	logic        prev_busy   = 1'b0;
	int          exp_row;          // Outstanding readout
	int          req_falls;
	int          req_edge;
	logic        req_open    = 1'b0;
	logic        req_busy    = 1'b0;

	life_top life_top_inst (
		.clk4         (clk4),
		.reset        (reset),
		.fire_button  (fire_button),
		.rd_req       (rd_req),
		.rd_row       (rd_row),
		.rd_data      (rd_data),
		.rd_valid     (rd_valid),
		.busy         (busy),
		.seed_done    (seed_done),
		.gen_count    (gen_count),
		.gens_per_sec (gens_per_sec)
	);

	initial clk4 = 1'b0;
	always #(PERIOD / 2) clk4 = ~clk4;

	always @(posedge clk4) begin
		if (reset)
			edge_cnt <= 0;
		else
			edge_cnt <= edge_cnt + 1;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Steps the stimulus LFSR once per bit
	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = stim_lfsr_next(stim_lfsr);
			v = (v << 1) | stim_lfsr[0];
		end
		return v;
	endfunction

	// Four-state compare, an unknown value counts as wrong
	task automatic check_int(input string what, input logic signed [63:0] got,
			input logic signed [63:0] want);
		check_count++;
		if (got !== want) begin
			$display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, want);
			error_count++;
		end
	endtask

	// Issues one readout and waits for rd_valid
	task automatic read_row(input int row);
		int waited;
		@(negedge clk4);
		exp_row   = row;
		req_busy  = busy;
		req_falls = fall_count;
		req_edge  = edge_cnt;
		req_open  = 1'b1;
		rd_req    = 1'b1;
		rd_row    = row[life_pkg::ROW_BITS-1:0];
		@(negedge clk4);
		rd_req = 1'b0;
		waited = 1;
		while (!rd_valid && waited < READ_TIMEOUT) begin
			@(negedge clk4);
			waited++;
		end
		if (!rd_valid) begin
			$display("Timeout at %0t: no rd_valid for row %0d", $time, row);
			error_count++;
			req_open = 1'b0;
		end
	endtask

	task automatic read_all_rows();
		for (int r = 0; r < life_pkg::LIFE_ROWS; r++)
			read_row(r);
	endtask

	task automatic press_button(input int cycles);
		@(negedge clk4);
		fire_button = 1'b1;
		repeat (cycles) @(negedge clk4);
		fire_button = 1'b0;
		repeat (RELEASE_WAIT) @(negedge clk4); // Let the pass and release filter finish
	endtask

	////////////////////////////////////////////////////////////
	// Model tracking and comparison
	////////////////////////////////////////////////////////////

	always @(negedge clk4) begin
		// Rate latched on the last edge of each window
		if (edge_cnt != 0 && edge_cnt % life_pkg::SECOND_CYCLES == 0) begin
			check_count++;
			if (int'(gens_per_sec) != win_falls) begin
				$display("Fail at %0t: gens_per_sec %0d, expected %0d", $time,
					gens_per_sec, win_falls);
				error_count++;
			end
			win_falls = 0;
		end
		if (prev_busy && !busy) begin
			model = life_generation(model); // New generation now current
			fall_count++;
			win_falls++;
		end
		prev_busy = busy;
		if (rd_valid) begin
			check_count++;
			if (!req_open) begin
				$display("Unexpected rd_valid at %0t with no readout outstanding", $time);
				error_count++;
			end else begin
				if (rd_data !== model[exp_row]) begin
					$display("Fail at %0t: row %0d is %h, expected %h", $time, exp_row,
						rd_data, model[exp_row]);
					error_count++;
				end
				if (req_busy && fall_count == req_falls) begin
					$display("Fail at %0t: readout served before busy fell", $time);
					error_count++;
				end
				if (!req_busy && edge_cnt - req_edge != 2) begin
					$display("Fail at %0t: idle readout took %0d cycles, expected 2",
						$time, edge_cnt - req_edge);
					error_count++;
				end
			end
			req_open = 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial begin
		int falls_before;
		int count_before;
		int len;
		int n;
		int target;
		logic busy_seen;
		reset       = 1'b1;
		fire_button = 1'b0;
		rd_req      = 1'b0;
		rd_row      = '0;
		stim_lfsr   = 16'd21448;
		model       = seed_grid();
		repeat (RESET_CYCLES) @(negedge clk4);
		reset = 1'b0;

		// Still reset values, no rising edge since release
		check_int("busy after reset", busy, 0);
		check_int("rd_valid after reset", rd_valid, 0);
		check_int("seed_done after reset", seed_done, 0);
		check_int("gen_count after reset", gen_count, 0);
		check_int("gens_per_sec after reset", gens_per_sec, 0);
		n = 0;
		while (!seed_done && n < SEED_WAIT) begin
			@(negedge clk4);
			n++;
		end
		if (!seed_done) begin
			$display("Timeout at %0t: seed_done never rose", $time);
			error_count++;
		end
		read_all_rows(); // Seed grid

		// Single generation from a short press
		falls_before = fall_count;
		press_button(40 + take_bits(6));
		check_int("passes after short press", fall_count - falls_before, 1);
		check_int("gen_count after short press", gen_count, 1);
		read_all_rows();

		// Glitches below the press time
		falls_before = fall_count;
		count_before = gen_count;
		busy_seen    = 1'b0;
		repeat (GLITCHES) begin
			len = 2 + take_bits(3);
			fire_button = 1'b1;
			repeat (len) begin
				@(negedge clk4);
				busy_seen = busy_seen | busy;
			end
			fire_button = 1'b0;
			repeat (GLITCH_GAP) begin
				@(negedge clk4);
				busy_seen = busy_seen | busy;
			end
		end
		check_int("busy during glitches", busy_seen, 0);
		check_int("passes from glitches", fall_count - falls_before, 0);
		check_int("gen_count after glitches", gen_count, count_before);

		// Hold mode, passes back to back
		falls_before = fall_count;
		press_button(300 + take_bits(7));
		if (fall_count - falls_before < 2) begin
			$display("Fail at %0t: hold mode ran %0d passes, expected at least 2",
				$time, fall_count - falls_before);
			error_count++;
		end
		check_int("gen_count after hold", gen_count, fall_count);
		read_all_rows();

		// Readout that collides with a pass
		falls_before = fall_count;
		@(negedge clk4);
		fire_button = 1'b1;
		n = 0;
		while (!busy && n < READ_TIMEOUT) begin
			@(negedge clk4);
			n++;
		end
		if (!busy) begin
			$display("No pass started at %0t for the colliding readout", $time);
			error_count++;
		end
		read_row(5);
		@(negedge clk4);
		fire_button = 1'b0;
		repeat (RELEASE_WAIT) @(negedge clk4);
		check_int("passes for colliding readout", fall_count - falls_before, 1);
		read_all_rows();

		// One full idle window must latch zero
		target = (edge_cnt / life_pkg::SECOND_CYCLES + 2) * life_pkg::SECOND_CYCLES;
		while (edge_cnt < target)
			@(negedge clk4);
		check_int("gens_per_sec after idle window", gens_per_sec, 0);
		check_int("final gen_count", gen_count, fall_count);

		$display("Summary: %0d checks, %0d errors, %0d generations", check_count,
			error_count, fall_count);
		if (error_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Run length bound from the phase lengths above
	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not complete",
			WATCHDOG_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+sim
design/life_pkg.sv
design/button_debounce.sv
design/life_seed.sv
design/life_grid_ram.sv
design/life_sequencer.sv
design/gen_stats.sv
design/life_top.sv
sim/tb_life_top.sv

/* Bender.yml */
package:
  name: life_top

sources:
  # Design sources
  - target: any(rtl, simulation)
    files:
      - design/life_pkg.sv
      - design/button_debounce.sv
      - design/life_seed.sv
      - design/life_grid_ram.sv
      - design/life_sequencer.sv
      - design/gen_stats.sv
      - design/life_top.sv

  # Testbench
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_life_top.sv
